// File: rtl/n64_vparams_pkg.sv
//////////////////////////////////////////////////
// Bus widths and pattern window limits per video mode
// Window limits are exclusive on both ends
//////////////////////////////////////////////////
package n64_vparams_pkg;

  //////////////////////////////////////////////////
  // Bus and counter widths
  //////////////////////////////////////////////////

  // One color channel as sent on the bus
  localparam int color_width = 7;
  // Sync nibble sits in the low bits of the bus
  localparam int sync_width = 4;
  // Pixel counter, wide enough for a full line
  localparam int hcnt_width = 10;
  // Line counter, wide enough for a PAL frame
  localparam int vcnt_width = 9;

  // More lines than this per frame means PAL
  localparam logic [vcnt_width-1:0] pal_line_threshold = 9'd287;

  //////////////////////////////////////////////////
  // Checkerboard window, NTSC
  //////////////////////////////////////////////////

  localparam logic [vcnt_width-1:0] vstart_ntsc = 9'd18;
  localparam logic [vcnt_width-1:0] vstop_ntsc  = 9'd248;
  localparam logic [hcnt_width-1:0] hstart_ntsc = 10'd40;
  localparam logic [hcnt_width-1:0] hstop_ntsc  = 10'd360;

  //////////////////////////////////////////////////
  // Checkerboard window, PAL
  //////////////////////////////////////////////////

  // Slightly lower and further right than NTSC
  localparam logic [vcnt_width-1:0] vstart_pal = 9'd22;
  localparam logic [vcnt_width-1:0] vstop_pal  = 9'd296;
  localparam logic [hcnt_width-1:0] hstart_pal = 10'd44;
  localparam logic [hcnt_width-1:0] hstop_pal  = 10'd364;

endpackage

// File: rtl/n64_vtypes_pkg.sv
//////////////////////////////////////////////////
// Pixel, sync and state types of the video pipeline
// All sync bits are active low
//////////////////////////////////////////////////
package n64_vtypes_pkg;

  //////////////////////////////////////////////////
  // Pixel layout
  //////////////////////////////////////////////////

  // Same bit order as the low nibble of the bus
  typedef struct packed {
    logic n_vsync;
    logic n_clamp;
    logic n_hsync;
    logic n_csync;
  } sync_t;

  // Sync on top, then red, green, blue; 25 bits in total
  typedef struct packed {
    sync_t                                   sync;
    logic [n64_vparams_pkg::color_width-1:0] red;
    logic [n64_vparams_pkg::color_width-1:0] green;
    logic [n64_vparams_pkg::color_width-1:0] blue;
  } pixel_t;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // Detected video standard
  typedef enum logic {
    VMODE_NTSC = 1'b0,
    VMODE_PAL  = 1'b1
  } vmode_t;

  // Bus phase within one pixel, PH_SYNC also means idle
  typedef enum logic [1:0] {
    PH_SYNC,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } demux_phase_t;

endpackage

// File: rtl/vdata_demux.sv
//////////////////////////////////////////////////
// Pixel is published one sync later, incomplete ones are dropped
// Needs nVDSYNC_i at least four cycles apart
//////////////////////////////////////////////////
`timescale 1ns/1ns

module vdata_demux (
  input  logic                                    VCLK,
  input  logic                                    nRST,
  input  logic                                    nVDSYNC_i,
  input  logic [n64_vparams_pkg::color_width-1:0] vd_i,
  output n64_vtypes_pkg::pixel_t                  pixel_o,
  output logic                                    nVDSYNC_o
);

  import n64_vparams_pkg::*;
  import n64_vtypes_pkg::*;

  // Bus phase of the pixel being collected
  demux_phase_t phase_q;
  // All three colors of the collected pixel are in
  logic         pix_done_q;
  // Pixel under assembly
  pixel_t       pix_asm;

  //////////////////////////////////////////////////
  // Phase FSM and output register
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      phase_q    <= PH_SYNC;
      pix_done_q <= 1'b0;
      pixel_o    <= '0;
      nVDSYNC_o  <= 1'b1;
    end else begin
      // Strobe lasts a single cycle
      nVDSYNC_o <= 1'b1;
      if (!nVDSYNC_i) begin
        // New sync closes the previous pixel
        if (pix_done_q) begin
          pixel_o   <= pix_asm;
          nVDSYNC_o <= 1'b0;
        end
        phase_q    <= PH_RED;
        pix_done_q <= 1'b0;
      end else begin
        case (phase_q)
          PH_RED:   phase_q <= PH_GREEN;
          PH_GREEN: phase_q <= PH_BLUE;
          PH_BLUE: begin
            phase_q    <= PH_SYNC;
            pix_done_q <= 1'b1;
          end
          // Idle until the next sync
          default:  phase_q <= PH_SYNC;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Payload capture
  //////////////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (!nVDSYNC_i) begin
      pix_asm.sync <= vd_i[sync_width-1:0];
    end else begin
      case (phase_q)
        PH_RED:   pix_asm.red   <= vd_i;
        PH_GREEN: pix_asm.green <= vd_i;
        PH_BLUE:  pix_asm.blue  <= vd_i;
        default:  pix_asm       <= pix_asm;
      endcase
    end
  end

  // Sync phase is a single-cycle pulse on the bus
  a_sync_single: assert property (
    @(posedge VCLK) disable iff (!nRST) !nVDSYNC_i |=> nVDSYNC_i
  );

endmodule

// File: rtl/vmode_detect.sv
//////////////////////////////////////////////////
// Mode output bypasses the register on the vsync pixel
//////////////////////////////////////////////////
`timescale 1ns/1ns

module vmode_detect (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  n64_vtypes_pkg::pixel_t pixel_i,
  input  logic                   nVDSYNC_i,
  output n64_vtypes_pkg::vmode_t vmode_o
);

  import n64_vparams_pkg::*;
  import n64_vtypes_pkg::*;

  // Sync of the last strobed pixel
  sync_t                 prev_sync_q;
  // Lines seen since the last vsync edge
  logic [vcnt_width-1:0] line_cnt_q;
  vmode_t                vmode_q;
  vmode_t                vmode_new;
  logic                  hs_rise;
  logic                  vs_rise;

  // Rising edges of the active-low syncs, strobed pixels only
  assign hs_rise = !nVDSYNC_i && pixel_i.sync.n_hsync && !prev_sync_q.n_hsync;
  assign vs_rise = !nVDSYNC_i && pixel_i.sync.n_vsync && !prev_sync_q.n_vsync;

  // Decision for the frame that just ended
  assign vmode_new = (line_cnt_q > pal_line_threshold) ? VMODE_PAL : VMODE_NTSC;

  // New mode already valid for the vsync pixel itself
  assign vmode_o = vs_rise ? vmode_new : vmode_q;

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      prev_sync_q <= '0;
      line_cnt_q  <= '0;
      vmode_q     <= VMODE_NTSC;
    end else if (!nVDSYNC_i) begin
      prev_sync_q <= pixel_i.sync;
      if (vs_rise) begin
        vmode_q    <= vmode_new;
        line_cnt_q <= '0;
      end else if (hs_rise) begin
        // Saturate on overlong frames
        line_cnt_q <= &line_cnt_q ? line_cnt_q : line_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: rtl/testpattern.sv
//////////////////////////////////////////////////
// Replaces colors by a checkerboard and passes sync through
// Counters start from sync edges and the window follows vmode_i
//////////////////////////////////////////////////
`timescale 1ns/1ns

module testpattern (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   nVDSYNC_i,
  input  n64_vtypes_pkg::pixel_t pixel_i,
  input  n64_vtypes_pkg::vmode_t vmode_i,
  output n64_vtypes_pkg::pixel_t pixel_o,
  output logic                   nVDSYNC_o
);

  import n64_vparams_pkg::*;
  import n64_vtypes_pkg::*;

  logic [hcnt_width-1:0] hcnt_q;
  logic [vcnt_width-1:0] vcnt_q;

  // Window limits of the current mode
  logic [vcnt_width-1:0] vstart;
  logic [vcnt_width-1:0] vstop;
  logic [hcnt_width-1:0] hstart;
  logic [hcnt_width-1:0] hstop;

  logic hs_rise;
  logic vs_rise;
  logic in_vwin;
  logic in_hwin;
  // Value copied into every color bit
  logic fill_bit;

  // Edges against the previous output sync
  assign hs_rise = pixel_i.sync.n_hsync && !pixel_o.sync.n_hsync;
  assign vs_rise = pixel_i.sync.n_vsync && !pixel_o.sync.n_vsync;

  always_comb begin
    if (vmode_i == VMODE_PAL) begin
      vstart = vstart_pal;
      vstop  = vstop_pal;
      hstart = hstart_pal;
      hstop  = hstop_pal;
    end else begin
      vstart = vstart_ntsc;
      vstop  = vstop_ntsc;
      hstart = hstart_ntsc;
      hstop  = hstop_ntsc;
    end
  end

  // Strict limits on both ends
  assign in_vwin = (vcnt_q > vstart) && (vcnt_q < vstop);
  assign in_hwin = (hcnt_q > hstart) && (hcnt_q < hstop);

  //////////////////////////////////////////////////
  // Checkerboard color
  //////////////////////////////////////////////////

  always_comb begin
    fill_bit = 1'b0;
    if (in_vwin) begin
      // Left border column alternates per line
      if (hcnt_q == hstart)
        fill_bit = vcnt_q[0];
      // Toggle against the last output pixel
      else if (in_hwin)
        fill_bit = ~pixel_o.red[0];
    end
  end

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      hcnt_q    <= '0;
      vcnt_q    <= '0;
      pixel_o   <= '0;
      nVDSYNC_o <= 1'b1;
    end else begin
      if (!nVDSYNC_i) begin
        if (hs_rise) begin
          hcnt_q <= '0;
          vcnt_q <= &vcnt_q ? vcnt_q : vcnt_q + 1'b1;
        end else begin
          hcnt_q <= &hcnt_q ? hcnt_q : hcnt_q + 1'b1;
        end
        // Vsync wins over the line step
        if (vs_rise)
          vcnt_q <= '0;

        pixel_o.sync  <= pixel_i.sync;
        pixel_o.red   <= {color_width{fill_bit}};
        pixel_o.green <= {color_width{fill_bit}};
        pixel_o.blue  <= {color_width{fill_bit}};
      end
      nVDSYNC_o <= nVDSYNC_i;
    end
  end

  // Line and frame lengths stay inside the counter range
  a_hcnt_nowrap: assert property (
    @(posedge VCLK) disable iff (!nRST) !(&hcnt_q)
  );
  a_vcnt_nowrap: assert property (
    @(posedge VCLK) disable iff (!nRST) !(&vcnt_q)
  );

endmodule

// File: rtl/vout_select.sv
//////////////////////////////////////////////////
// Pattern enable only takes effect at a vsync edge
// live_i must still hold its pixel on the pattern strobe
//////////////////////////////////////////////////
`timescale 1ns/1ns

module vout_select (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   nVDSYNC_i,
  input  n64_vtypes_pkg::pixel_t pattern_i,
  input  n64_vtypes_pkg::pixel_t live_i,
  input  logic                   pattern_en_i,
  output n64_vtypes_pkg::pixel_t pixel_o,
  output logic                   nVDSYNC_o
);

  // Vsync of the previous pattern pixel
  logic prev_vsync_q;
  // Selection latched at the last frame start
  logic sel_q;
  logic sel_now;
  logic vs_rise;

  assign vs_rise = !nVDSYNC_i && pattern_i.sync.n_vsync && !prev_vsync_q;

  // First pixel of a new frame already follows the new enable
  assign sel_now = vs_rise ? pattern_en_i : sel_q;

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      prev_vsync_q <= 1'b0;
      sel_q        <= 1'b0;
      pixel_o      <= '0;
      nVDSYNC_o    <= 1'b1;
    end else begin
      if (!nVDSYNC_i) begin
        prev_vsync_q <= pattern_i.sync.n_vsync;
        sel_q        <= sel_now;
        pixel_o      <= sel_now ? pattern_i : live_i;
      end
      nVDSYNC_o <= nVDSYNC_i;
    end
  end

  // Pixel strobe at the output is a single-cycle pulse
  a_strobe_single: assert property (
    @(posedge VCLK) disable iff (!nRST) !nVDSYNC_o |=> nVDSYNC_o
  );

endmodule

// File: rtl/n64_video_top.sv
//////////////////////////////////////////////////
// nVDSYNC_o follows the completing bus sync by three cycles
//////////////////////////////////////////////////
`timescale 1ns/1ns

module n64_video_top (
  input  logic                                    VCLK,
  input  logic                                    nRST,
  input  logic                                    nVDSYNC_i,
  input  logic [n64_vparams_pkg::color_width-1:0] vd_i,
  input  logic                                    pattern_en_i,
  output n64_vtypes_pkg::pixel_t                  pixel_o,
  output logic                                    nVDSYNC_o,
  output n64_vtypes_pkg::vmode_t                  vmode_o
);

  import n64_vtypes_pkg::*;

  //////////////////////////////////////////////////
  // Pipeline links
  //////////////////////////////////////////////////

  // Parallel pixels from the bus
  pixel_t dmx_pixel;
  logic   dmx_nstrobe;
  // Detected standard
  vmode_t vmode;
  // Checkerboard pixels
  pixel_t tp_pixel;
  logic   tp_nstrobe;

  vdata_demux u_demux (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .nVDSYNC_i (nVDSYNC_i),
    .vd_i      (vd_i),
    .pixel_o   (dmx_pixel),
    .nVDSYNC_o (dmx_nstrobe)
  );

  vmode_detect u_vmode (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .pixel_i   (dmx_pixel),
    .nVDSYNC_i (dmx_nstrobe),
    .vmode_o   (vmode)
  );

  testpattern u_testpattern (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .nVDSYNC_i (dmx_nstrobe),
    .pixel_i   (dmx_pixel),
    .vmode_i   (vmode),
    .pixel_o   (tp_pixel),
    .nVDSYNC_o (tp_nstrobe)
  );

  // Live path taps the demux, one stage behind the pattern
  vout_select u_select (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .nVDSYNC_i    (tp_nstrobe),
    .pattern_i    (tp_pixel),
    .live_i       (dmx_pixel),
    .pattern_en_i (pattern_en_i),
    .pixel_o      (pixel_o),
    .nVDSYNC_o    (nVDSYNC_o)
  );

  assign vmode_o = vmode;

endmodule

// File: bench/tb_video_model.svh
//////////////////////////////////////////////////
// Pixel-level reference model and sync generator
// Included inside the testbench module body
//////////////////////////////////////////////////
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

// Line layout of the generated video
localparam int line_pixels = 400;
localparam int hsync_len   = 30;
localparam int vsync_lines = 3;
// Saturation points of the pipeline counters
localparam int hcnt_max    = (1 << hcnt_width) - 1;
localparam int vcnt_max    = (1 << vcnt_width) - 1;

// Model state, starts like the pipeline after reset
sync_t  m_prev_sync = '0;
int     m_line_cnt  = 0;
vmode_t m_mode      = VMODE_NTSC;
int     m_hcnt      = 0;
int     m_vcnt      = 0;
// Lowest red bit of the last checkerboard pixel
logic   m_prev_red0 = 1'b0;
// Picture or pattern, as chosen at the last frame start
logic   m_sel       = 1'b0;

// Sync nibble for one pixel of a frame, vsync and hsync at the start
function automatic sync_t frame_sync(input int line, input int pix);
  sync_t s;
  s.n_vsync = (line >= vsync_lines);
  s.n_hsync = (pix >= hsync_len);
  // Clamp pulse on the back porch
  s.n_clamp = !((pix >= 32) && (pix < 40));
  // Composite sync inverts during vsync
  s.n_csync = s.n_vsync ? s.n_hsync : !s.n_hsync;
  return s;
endfunction

// Expected output pixel for one input pixel, pen is the enable at its selection
function automatic pixel_t predict_pixel(input pixel_t in_pix, input logic pen);
  logic   hs_rise;
  logic   vs_rise;
  logic   fill;
  int     vstart;
  int     vstop;
  int     hstart;
  int     hstop;
  pixel_t tp_pix;
  hs_rise = in_pix.sync.n_hsync && !m_prev_sync.n_hsync;
  vs_rise = in_pix.sync.n_vsync && !m_prev_sync.n_vsync;
  // Lines of the frame that just ended pick the mode
  if (vs_rise) begin
    m_mode     = (m_line_cnt > pal_line_threshold) ? VMODE_PAL : VMODE_NTSC;
    m_line_cnt = 0;
  end else if (hs_rise && (m_line_cnt < vcnt_max)) begin
    m_line_cnt++;
  end
  // Window of the mode, new mode already holds on the vsync pixel
  vstart = (m_mode == VMODE_PAL) ? vstart_pal : vstart_ntsc;
  vstop  = (m_mode == VMODE_PAL) ? vstop_pal  : vstop_ntsc;
  hstart = (m_mode == VMODE_PAL) ? hstart_pal : hstart_ntsc;
  hstop  = (m_mode == VMODE_PAL) ? hstop_pal  : hstop_ntsc;
  fill = 1'b0;
  if ((m_vcnt > vstart) && (m_vcnt < vstop)) begin
    // Left border follows line parity
    if (m_hcnt == hstart)
      fill = ((m_vcnt % 2) != 0);
    else if ((m_hcnt > hstart) && (m_hcnt < hstop))
      fill = !m_prev_red0;
  end
  tp_pix.sync  = in_pix.sync;
  tp_pix.red   = {color_width{fill}};
  tp_pix.green = {color_width{fill}};
  tp_pix.blue  = {color_width{fill}};
  m_prev_red0  = fill;
  // Counters step after the color is chosen
  if (hs_rise) begin
    m_hcnt = 0;
    if (m_vcnt < vcnt_max)
      m_vcnt++;
  end else if (m_hcnt < hcnt_max) begin
    m_hcnt++;
  end
  if (vs_rise) begin
    m_vcnt = 0;
    m_sel  = pen;
  end
  m_prev_sync = in_pix.sync;
  return m_sel ? tp_pix : in_pix;
endfunction

`endif

// File: bench/tb_n64_video.sv
//////////////////////////////////////////////////
// Random full frames through the pipeline, checked pixel by pixel
// Several complete frames, so the run takes a while
//////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_n64_video;

  import n64_vparams_pkg::*;
  import n64_vtypes_pkg::*;

  localparam int num_frames = 4;
  localparam int ntsc_lines = 262;
  localparam int pal_lines  = 312;

  logic                   VCLK;
  logic                   nRST;
  logic                   nVDSYNC_i;
  logic [color_width-1:0] vd_i;
  logic                   pattern_en_i;
  pixel_t                 pixel_o;
  logic                   nVDSYNC_o;
  vmode_t                 vmode_o;

  logic [31:0] rng_state = 32'd39;
  // Line count and enable of each frame
  int          frame_lines [num_frames];
  logic        frame_pen   [num_frames];
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  // Expected output for the previous input pixel
  logic        pending;
  pixel_t      exp_pix;
  vmode_t      exp_mode;

  `include "tb_video_model.svh"

  n64_video_top uut (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .nVDSYNC_i    (nVDSYNC_i),
    .vd_i         (vd_i),
    .pattern_en_i (pattern_en_i),
    .pixel_o      (pixel_o),
    .nVDSYNC_o    (nVDSYNC_o),
    .vmode_o      (vmode_o)
  );

  initial begin
    VCLK = 1'b0;
    forever #2 VCLK = ~VCLK;
  end

  // Watchdog, limit is set once the frames are planned
  always @(posedge VCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
      $display("Timeout after %0d cycles before all frames were checked", cycle_cnt);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "check failed");
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_vmode(input string name, input vmode_t got, input vmode_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  // One pixel on the bus, sync then three colors; checks the output strobe each cycle
  task automatic send_pixel(input pixel_t pix);
    logic [31:0]            r;
    logic [color_width-1:0] bytes [4];
    r = next_rand();
    // Upper bits of the sync byte carry junk
    bytes[0] = {r[2:0], pix.sync};
    bytes[1] = pix.red;
    bytes[2] = pix.green;
    bytes[3] = pix.blue;
    for (int i = 0; i < 4; i++) begin
      @(negedge VCLK);
      // Previous pixel is due three cycles after this sync
      if ((i == 3) && pending) begin
        if (nVDSYNC_o !== 1'b0)
          stop_on_error("Output strobe missing three cycles after the completing sync");
        check_pixel("pixel_o", pixel_o, exp_pix);
        check_vmode("vmode_o", vmode_o, exp_mode);
      end else if (nVDSYNC_o !== 1'b1) begin
        stop_on_error("Output strobe low on a cycle where no pixel was due");
      end
      nVDSYNC_i = (i != 0);
      vd_i      = bytes[i];
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    pixel_t      cur;
    pixel_t      prev;
    logic        have_prev;
    int          total;
    logic [31:0] r;
    nRST         = 1'b0;
    nVDSYNC_i    = 1'b1;
    vd_i         = '0;
    pattern_en_i = 1'b0;
    pending      = 1'b0;
    exp_pix      = '0;
    exp_mode     = VMODE_NTSC;
    have_prev    = 1'b0;
    prev         = '0;
    total        = 0;

    // Opening frames fixed: live NTSC, pattern on after it, PAL window next
    for (int f = 0; f < num_frames; f++) begin
      r = next_rand();
      frame_lines[f] = r[0] ? pal_lines : ntsc_lines;
      frame_pen[f]   = r[1];
      if (f == 0) begin
        frame_lines[f] = ntsc_lines;
        frame_pen[f]   = 1'b0;
      end else if (f == 1) begin
        frame_lines[f] = pal_lines;
        frame_pen[f]   = 1'b1;
      end else if (f == 2) begin
        frame_pen[f] = 1'b1;
      end
      total += frame_lines[f] * line_pixels;
    end
    // Four cycles per pixel plus the closing sync and reset
    cycle_limit  = (total + 1) * 4 + 64;
    pattern_en_i = frame_pen[0];

    repeat (3) @(posedge VCLK);
    @(negedge VCLK);
    nRST = 1'b1;

    for (int f = 0; f < num_frames; f++) begin
      for (int l = 0; l < frame_lines[f]; l++) begin
        for (int p = 0; p < line_pixels; p++) begin
          // Enable of the next frame changes in mid-frame
          if ((l == frame_lines[f] / 2) && (p == 0) && (f + 1 < num_frames))
            pattern_en_i = frame_pen[f + 1];
          r         = next_rand();
          cur.sync  = frame_sync(l, p);
          cur.red   = r[6:0];
          cur.green = r[13:7];
          cur.blue  = r[20:14];
          if (have_prev) begin
            exp_pix  = predict_pixel(prev, pattern_en_i);
            exp_mode = m_mode;
            pending  = 1'b1;
          end
          send_pixel(cur);
          prev      = cur;
          have_prev = 1'b1;
        end
      end
    end

    // Closing sync publishes the last pixel
    exp_pix  = predict_pixel(prev, pattern_en_i);
    exp_mode = m_mode;
    pending  = 1'b1;
    cur      = '0;
    cur.sync = frame_sync(0, 0);
    send_pixel(cur);
    pending = 1'b0;

    // Bus idle, the unfinished pixel must stay inside
    repeat (8) begin
      @(negedge VCLK);
      if (nVDSYNC_o !== 1'b1)
        stop_on_error("Output strobe low while the bus was idle");
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: sources.f
+incdir+bench
rtl/n64_vparams_pkg.sv
rtl/n64_vtypes_pkg.sv
rtl/vdata_demux.sv
rtl/vmode_detect.sv
rtl/testpattern.sv
rtl/vout_select.sv
rtl/n64_video_top.sv
bench/tb_n64_video.sv
